/* sfp_board_top.f */
+incdir+verilog
verilog/sfp_pkg.sv
verilog/wb_pkg.sv
verilog/reset_sync.sv
verilog/status_sync.sv
verilog/sfp_ctrl_regs.sv
verilog/sfp_led_ctrl.sv
verilog/sfp_board_top.sv
tests/sfp_board_props.sv
tests/sfp_board_tb.sv

/* Bender.yml */
package:
  name: sfp_board

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sfp_pkg.sv
      - verilog/wb_pkg.sv
      - verilog/reset_sync.sv
      - verilog/status_sync.sv
      - verilog/sfp_ctrl_regs.sv
      - verilog/sfp_led_ctrl.sv
      - verilog/sfp_board_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/sfp_board_props.sv
      - tests/sfp_board_tb.sv

/* tests/sfp_board_tb.sv */
// SFP board testbench
`timescale 1ns/1ps
`include "sfp_consts.svh"

module sfp_board_tb;

import wb_pkg::*;
import sfp_pkg::*;

localparam int SYNC_WAIT = `SFP_SYNC_STAGES + 1;
localparam int LED_WAIT  = `SFP_SYNC_STAGES + 3;
localparam int ACK_LIMIT = 16;
// The tests need well under a thousand cycles
localparam int MAX_CYCLES = 5000;

logic       clk_125mhz_int;
logic       reset_i;
logic       sfp_mod_abs;
logic       sfp_rx_los;
logic       sfp_tx_fault;
logic       scl_force_low;
logic       sda_force_low;
logic       sfp_scl;
logic       sfp_sda;
wb_req_t    wb_req;
wb_rsp_t    wb_rsp;
logic       sfp_tx_disable;
logic       sfp_scl_oe;
logic       sfp_sda_oe;
logic [1:0] led;
logic [1:0] sfp_led;

// Testbench copy of the register state
sfp_ctrl_t  ctrl_model;
sfp_event_t pend_model;

int errors;
int checks;
int tests_run;
int tests_bad;
int cycles;

sfp_board_top UUT (
    .clk_125mhz_int(clk_125mhz_int),
    .reset_i(reset_i),
    .sfp_mod_abs_i(sfp_mod_abs),
    .sfp_rx_los_i(sfp_rx_los),
    .sfp_tx_fault_i(sfp_tx_fault),
    .sfp_scl_i(sfp_scl),
    .sfp_sda_i(sfp_sda),
    .wb_req_i(wb_req),
    .wb_rsp_o(wb_rsp),
    .sfp_tx_disable_o(sfp_tx_disable),
    .sfp_scl_oe_o(sfp_scl_oe),
    .sfp_sda_oe_o(sfp_sda_oe),
    .led_o(led),
    .sfp_led_o(sfp_led)
);

// Pull-ups, low while the DUT or the testbench pulls the line
assign sfp_scl = !(sfp_scl_oe || scl_force_low);
assign sfp_sda = !(sfp_sda_oe || sda_force_low);

always #4 clk_125mhz_int = ~clk_125mhz_int;

always @(posedge clk_125mhz_int) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("tests failed");
        $finish;
    end
end

task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
endtask

// Register values as the map defines them
function automatic wb_data_t expected_reg(input int addr);
    wb_data_t val;
    val = '0;
    case (addr)
        `SFP_REG_CTRL: begin
            val[0] = ctrl_model.tx_disable;
            val[1] = ctrl_model.scl_low;
            val[2] = ctrl_model.sda_low;
        end
        `SFP_REG_STATUS: begin
            val[0] = sfp_mod_abs;
            val[1] = sfp_rx_los;
            val[2] = sfp_tx_fault;
            val[3] = !(ctrl_model.scl_low || scl_force_low);
            val[4] = !(ctrl_model.sda_low || sda_force_low);
        end
        `SFP_REG_EVENT: begin
            val[0] = pend_model.mod_abs_rise;
            val[1] = pend_model.rx_los_rise;
            val[2] = pend_model.tx_fault_rise;
        end
        `SFP_REG_ID: val = `SFP_ID_VALUE;
        default: val = '0;
    endcase
    return val;
endfunction

function automatic logic link_expected();
    return !sfp_mod_abs && !sfp_rx_los && !ctrl_model.tx_disable;
endfunction

function automatic logic led_bit(input int which);
    if (which == 0) begin
        return led[0];
    end else begin
        return sfp_led[1];
    end
endfunction

task automatic model_write(input int addr, input wb_data_t data);
    if (addr == `SFP_REG_CTRL) begin
        ctrl_model.tx_disable = data[0];
        ctrl_model.scl_low    = data[1];
        ctrl_model.sda_low    = data[2];
    end else if (addr == `SFP_REG_EVENT) begin
        pend_model = pend_model & ~sfp_event_t'(data[2:0]);
    end
endtask

task automatic wait_cycles(input int n);
    repeat (n) begin
        @(posedge clk_125mhz_int);
        #1;
    end
endtask

task automatic set_pins(input logic abs, input logic los, input logic fault,
                        input logic scl_low, input logic sda_low);
    // Rising edges of the status pins become sticky events
    pend_model.mod_abs_rise  = pend_model.mod_abs_rise | (abs && !sfp_mod_abs);
    pend_model.rx_los_rise   = pend_model.rx_los_rise | (los && !sfp_rx_los);
    pend_model.tx_fault_rise = pend_model.tx_fault_rise | (fault && !sfp_tx_fault);
    sfp_mod_abs   = abs;
    sfp_rx_los    = los;
    sfp_tx_fault  = fault;
    scl_force_low = scl_low;
    sda_force_low = sda_low;
endtask

task automatic bus_cycle(input logic we, input int addr, input wb_data_t wdata,
                         output wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: wb_addr_t'(addr), dat: wdata};
    do begin
        wait_cycles(1);
        waited++;
    end while (wb_rsp.ack !== 1'b1 && waited < ACK_LIMIT);
    if (wb_rsp.ack !== 1'b1) begin
        errors++;
        $display("No ack from the register block within %0d cycles for word %0d",
                 ACK_LIMIT, addr);
    end else begin
        rdata = wb_rsp.dat;
        if (we) begin
            model_write(addr, wdata);
        end
    end
    // Strobe low for a cycle before the next access
    wb_req = '0;
    wait_cycles(1);
endtask

task automatic wb_write(input int addr, input wb_data_t data);
    wb_data_t unused;
    bus_cycle(1'b1, addr, data, unused);
endtask

task automatic wb_read(input int addr, output wb_data_t data);
    bus_cycle(1'b0, addr, '0, data);
endtask

task automatic read_check(input int addr, input string what);
    wb_data_t got;
    wb_read(addr, got);
    check(got, expected_reg(addr), what);
endtask

// Cycles between two toggles of an LED, -1 if none seen
task automatic measure_toggle(input int which, input int limit, output int period);
    logic last;
    int   n;
    period = -1;
    last   = led_bit(which);
    n      = 0;
    while (n < limit && led_bit(which) == last) begin
        wait_cycles(1);
        n++;
    end
    if (led_bit(which) != last) begin
        last = led_bit(which);
        n    = 0;
        do begin
            wait_cycles(1);
            n++;
        end while (n < limit && led_bit(which) == last);
        if (led_bit(which) != last) begin
            period = n;
        end
    end
endtask

task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
        $display("%s: ok", name);
    end else begin
        tests_bad++;
        $display("%s: %0d errors", name, errors - errors_before);
    end
endtask

initial begin
    logic [31:0] pat;
    logic        lit;
    int          period;
    int          mark;
    int unsigned seed_ret;

    seed_ret       = $urandom(32'hf834_12a0);
    clk_125mhz_int = 1'b0;
    reset_i        = 1'b1;
    wb_req         = '0;
    sfp_mod_abs    = 1'b0;
    sfp_rx_los     = 1'b0;
    sfp_tx_fault   = 1'b0;
    scl_force_low  = 1'b0;
    sda_force_low  = 1'b0;
    ctrl_model     = '{sda_low: 1'b0, scl_low: 1'b0, tx_disable: 1'b1};
    pend_model     = '0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_bad      = 0;
    cycles         = 0;
    repeat (2) @(posedge clk_125mhz_int);
    #1;
    reset_i = 1'b0;
    wait_cycles(`SFP_RST_STAGES + 1);

    mark = errors;
    check(sfp_tx_disable, 1'b1, "tx_disable after reset");
    check(sfp_scl_oe, 1'b0, "scl_oe after reset");
    check(sfp_sda_oe, 1'b0, "sda_oe after reset");
    check(wb_rsp.ack, 1'b0, "ack after reset");
    check({led, sfp_led}, 4'b0000, "LEDs after reset");
    read_check(`SFP_REG_ID, "ID register");
    read_check(`SFP_REG_EVENT, "event register after reset");
    read_check(`SFP_REG_CTRL, "control register after reset");
    end_test("reset state", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) begin
        wb_write(`SFP_REG_CTRL, $urandom);
        check(sfp_tx_disable, ctrl_model.tx_disable, "tx_disable pin");
        check(sfp_scl_oe, ctrl_model.scl_low, "scl_oe pin");
        check(sfp_sda_oe, ctrl_model.sda_low, "sda_oe pin");
        read_check(`SFP_REG_CTRL, "control read back");
        wait_cycles(SYNC_WAIT);
        read_check(`SFP_REG_STATUS, "bus levels in status");
        wb_write(`SFP_REG_STATUS, $urandom);
        wb_write(`SFP_REG_ID, $urandom);
        read_check(`SFP_REG_STATUS, "status after write");
        read_check(`SFP_REG_ID, "ID after write");
        read_check(`SFP_REG_CTRL, "control after read-only writes");
    end
    wb_write(`SFP_REG_CTRL, 32'h1);
    end_test("control round trip", mark);

    mark = errors;
    for (int i = 0; i < 12; i++) begin
        pat = $urandom;
        set_pins(pat[0], pat[1], pat[2], pat[3], pat[4]);
        wait_cycles(SYNC_WAIT);
        read_check(`SFP_REG_STATUS, "synchronized status");
    end
    read_check(`SFP_REG_EVENT, "events from random pins");
    end_test("status synchronization", mark);

    mark = errors;
    set_pins(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_cycles(SYNC_WAIT);
    wb_write(`SFP_REG_EVENT, 32'h7);
    read_check(`SFP_REG_EVENT, "events cleared");
    set_pins(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_cycles(SYNC_WAIT);
    read_check(`SFP_REG_EVENT, "mod_abs rise");
    set_pins(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
    wait_cycles(SYNC_WAIT);
    read_check(`SFP_REG_EVENT, "rx_los and tx_fault rise");
    wb_write(`SFP_REG_EVENT, 32'h2);
    read_check(`SFP_REG_EVENT, "clear of rx_los only");
    wb_write(`SFP_REG_EVENT, 32'h5);
    read_check(`SFP_REG_EVENT, "clear of the rest");
    // Falling edges with nothing pending
    set_pins(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_cycles(SYNC_WAIT);
    read_check(`SFP_REG_EVENT, "falling edges");
    set_pins(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    wait_cycles(SYNC_WAIT);
    read_check(`SFP_REG_EVENT, "rx_los rise after clear");
    end_test("sticky events", mark);

    mark = errors;
    set_pins(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    wb_write(`SFP_REG_CTRL, 32'h0);
    wait_cycles(LED_WAIT);
    check(sfp_led[0], link_expected(), "link LED with link up");
    set_pins(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    wait_cycles(LED_WAIT);
    check(sfp_led[0], link_expected(), "link LED with loss of signal");
    set_pins(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_cycles(LED_WAIT);
    check(sfp_led[0], link_expected(), "link LED with module absent");
    set_pins(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    wb_write(`SFP_REG_CTRL, 32'h1);
    wait_cycles(LED_WAIT);
    check(sfp_led[0], link_expected(), "link LED with laser off");
    check(led[1], |pend_model, "event LED with events pending");
    wb_write(`SFP_REG_EVENT, 32'h7);
    wait_cycles(2);
    check(led[1], |pend_model, "event LED after clear");
    set_pins(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    wait_cycles(LED_WAIT);
    measure_toggle(1, 4 * `SFP_BLINK_DIV, period);
    check(period, `SFP_BLINK_DIV, "fault LED toggle period");
    set_pins(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_cycles(LED_WAIT);
    lit = 1'b0;
    repeat (2 * `SFP_BLINK_DIV) begin
        lit = lit | sfp_led[1];
        wait_cycles(1);
    end
    check(lit, 1'b0, "fault LED without fault");
    measure_toggle(0, 3 * `SFP_HEARTBEAT_DIV, period);
    check(period, `SFP_HEARTBEAT_DIV, "heartbeat period");
    end_test("LEDs", mark);

    errors = errors + UUT.ctrl_regs_inst.props_inst.assert_errors;
    $display("%0d tests, %0d with errors, %0d checks, %0d assertion failures, %0d errors",
             tests_run, tests_bad, checks, UUT.ctrl_regs_inst.props_inst.assert_errors,
             errors);
    if (errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

/* tests/sfp_board_props.sv */
// Register block bus and reset properties
`timescale 1ns/1ps

module sfp_board_props (
    input logic                clk_125mhz_int,
    input logic                rst_i,
    input wb_pkg::wb_req_t     wb_req_i,
    input wb_pkg::wb_rsp_t     wb_rsp_i,
    input sfp_pkg::sfp_ctrl_t  ctrl_i
);

// Count of failed assertions
int assert_errors = 0;

// Ack answers a request that was on the bus at the previous edge
ack_after_request: assert property (@(posedge clk_125mhz_int)
    $rose(wb_rsp_i.ack) |-> $past(wb_req_i.cyc && wb_req_i.stb))
    else begin
        assert_errors++;
        $error("ack rose without cyc and stb");
    end

ack_single_cycle: assert property (@(posedge clk_125mhz_int)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
        assert_errors++;
        $error("ack held for two cycles");
    end

// Laser stays off through reset
tx_off_in_reset: assert property (@(posedge clk_125mhz_int)
    rst_i |=> ctrl_i.tx_disable)
    else begin
        assert_errors++;
        $error("tx_disable low during reset");
    end

ack_low_in_reset: assert property (@(posedge clk_125mhz_int)
    rst_i |=> !wb_rsp_i.ack)
    else begin
        assert_errors++;
        $error("ack high during reset");
    end

endmodule

bind sfp_ctrl_regs sfp_board_props props_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst_i(rst_i),
    .wb_req_i(wb_req_i),
    .wb_rsp_i(wb_rsp_o),
    .ctrl_i(ctrl_o)
);

/* verilog/sfp_board_top.sv */
// SFP cage management top level
`timescale 1ns/1ps

module sfp_board_top (
    input  logic               clk_125mhz_int,
    input  logic               reset_i,

    // Cage status pins and I2C line levels
    input  logic               sfp_mod_abs_i,
    input  logic               sfp_rx_los_i,
    input  logic               sfp_tx_fault_i,
    input  logic               sfp_scl_i,
    input  logic               sfp_sda_i,

    // Host register bus
    input  wb_pkg::wb_req_t    wb_req_i,
    output wb_pkg::wb_rsp_t    wb_rsp_o,

    // Cage control, I2C as open-drain enables
    output logic               sfp_tx_disable_o,
    output logic               sfp_scl_oe_o,
    output logic               sfp_sda_oe_o,

    // LEDs
    output logic [1:0]         led_o,
    output logic [1:0]         sfp_led_o
);

import sfp_pkg::*;

logic       rst;
sfp_pins_t  pins_raw;
sfp_pins_t  pins_q;
sfp_event_t events;
sfp_event_t pending;
sfp_ctrl_t  ctrl;

// Pad levels into one word
assign pins_raw.mod_abs  = sfp_mod_abs_i;
assign pins_raw.rx_los   = sfp_rx_los_i;
assign pins_raw.tx_fault = sfp_tx_fault_i;
assign pins_raw.scl      = sfp_scl_i;
assign pins_raw.sda      = sfp_sda_i;

reset_sync
reset_sync_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .reset_i(reset_i),
    .rst_o(rst)
);

status_sync
status_sync_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst_i(rst),
    .pins_i(pins_raw),
    .pins_o(pins_q),
    .events_o(events)
);

sfp_ctrl_regs
ctrl_regs_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst_i(rst),
    .wb_req_i(wb_req_i),
    .wb_rsp_o(wb_rsp_o),
    .pins_i(pins_q),
    .events_i(events),
    .ctrl_o(ctrl),
    .pending_o(pending)
);

sfp_led_ctrl
led_ctrl_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst_i(rst),
    .pins_i(pins_q),
    .tx_disable_i(ctrl.tx_disable),
    .pending_i(pending),
    .led_o(led_o),
    .sfp_led_o(sfp_led_o)
);

// Control word out to the cage
assign sfp_tx_disable_o = ctrl.tx_disable;
assign sfp_scl_oe_o     = ctrl.scl_low;
assign sfp_sda_oe_o     = ctrl.sda_low;

endmodule

/* verilog/sfp_led_ctrl.sv */
// Board and cage LED controller
`timescale 1ns/1ps
`include "sfp_consts.svh"

module sfp_led_ctrl (
    input  logic                   clk_125mhz_int,
    input  logic                   rst_i,
    input  sfp_pkg::sfp_pins_t     pins_i,
    input  logic                   tx_disable_i,
    input  sfp_pkg::sfp_event_t    pending_i,
    output logic [1:0]             led_o,
    output logic [1:0]             sfp_led_o
);

localparam int HB_DIV    = `SFP_HEARTBEAT_DIV;
localparam int BLINK_DIV = `SFP_BLINK_DIV;
localparam int HB_W      = $clog2(HB_DIV);
localparam int BLINK_W   = $clog2(BLINK_DIV);

logic [HB_W-1:0]    hb_cnt_q;
logic [BLINK_W-1:0] blink_cnt_q;
logic               hb_q;
logic               pend_led_q;
logic               link_led_q;
logic               fault_led_q;
logic               link_up;

// Module present, signal seen and laser on
assign link_up = !pins_i.mod_abs && !pins_i.rx_los && !tx_disable_i;

// Heartbeat, toggles every HB_DIV cycles
always_ff @(posedge clk_125mhz_int) begin
    if (rst_i) begin
        hb_cnt_q <= '0;
        hb_q     <= 1'b0;
    end else if (hb_cnt_q == HB_W'(HB_DIV - 1)) begin
        hb_cnt_q <= '0;
        hb_q     <= ~hb_q;
    end else begin
        hb_cnt_q <= hb_cnt_q + 1'b1;
    end
end

// Fault blink restarts on every fault, first toggle turns it on
always_ff @(posedge clk_125mhz_int) begin
    if (rst_i || !pins_i.tx_fault) begin
        blink_cnt_q <= '0;
        fault_led_q <= 1'b0;
    end else begin
        if (blink_cnt_q == '0) begin
            fault_led_q <= ~fault_led_q;
        end
        if (blink_cnt_q == BLINK_W'(BLINK_DIV - 1)) begin
            blink_cnt_q <= '0;
        end else begin
            blink_cnt_q <= blink_cnt_q + 1'b1;
        end
    end
end

// Steady indicators
always_ff @(posedge clk_125mhz_int) begin
    if (rst_i) begin
        link_led_q <= 1'b0;
        pend_led_q <= 1'b0;
    end else begin
        link_led_q <= link_up;
        pend_led_q <= |pending_i;
    end
end

assign led_o     = {pend_led_q, hb_q};
assign sfp_led_o = {fault_led_q, link_led_q};

endmodule

/* verilog/sfp_ctrl_regs.sv */
// SFP management register block
`timescale 1ns/1ps
`include "sfp_consts.svh"

module sfp_ctrl_regs (
    input  logic                   clk_125mhz_int,
    input  logic                   rst_i,

    // Wishbone classic slave
    input  wb_pkg::wb_req_t        wb_req_i,
    output wb_pkg::wb_rsp_t        wb_rsp_o,

    // Synchronized cage pins and their edge pulses
    input  sfp_pkg::sfp_pins_t     pins_i,
    input  sfp_pkg::sfp_event_t    events_i,

    // Control word and sticky events
    output sfp_pkg::sfp_ctrl_t     ctrl_o,
    output sfp_pkg::sfp_event_t    pending_o
);

import wb_pkg::*;
import sfp_pkg::*;

localparam int CTRL_W  = $bits(sfp_ctrl_t);
localparam int EVENT_W = $bits(sfp_event_t);
localparam int PINS_W  = $bits(sfp_pins_t);

// Laser off and both I2C lines released
localparam sfp_ctrl_t CTRL_RESET = '{sda_low: 1'b0, scl_low: 1'b0, tx_disable: 1'b1};

logic       req_valid;
logic       req_seen_q;
logic       access;
logic       wr_access;
logic       ack_q;
logic       wr_ctrl;
wb_data_t   rdata;
wb_data_t   rdata_q;
sfp_ctrl_t  ctrl_q;
sfp_event_t pending_q;
sfp_event_t clear_mask;

// Bus cycle decode

assign req_valid = wb_req_i.cyc && wb_req_i.stb;

// Only the first cycle of a strobe is served
// A held strobe gets no second ack
assign access    = req_valid && !req_seen_q;
assign wr_access = access && wb_req_i.we;

always_ff @(posedge clk_125mhz_int) begin
    if (rst_i) begin
        ack_q      <= 1'b0;
        req_seen_q <= 1'b0;
    end else begin
        ack_q      <= access;
        req_seen_q <= req_valid;
    end
end

// Read mux
// Unmapped words read as zero
always_comb begin
    rdata = '0;
    case (wb_req_i.adr)
        wb_addr_t'(`SFP_REG_CTRL): begin
            rdata[CTRL_W-1:0] = ctrl_q;
        end
        wb_addr_t'(`SFP_REG_STATUS): begin
            rdata[PINS_W-1:0] = pins_i;
        end
        wb_addr_t'(`SFP_REG_EVENT): begin
            rdata[EVENT_W-1:0] = pending_q;
        end
        wb_addr_t'(`SFP_REG_ID): begin
            rdata = `SFP_ID_VALUE;
        end
        default: begin
            rdata = '0;
        end
    endcase
end

// Captured on the ack edge, valid while ack is high
always_ff @(posedge clk_125mhz_int) begin
    if (access) begin
        rdata_q <= rdata;
    end
end

// Control register

assign wr_ctrl = wr_access && (wb_req_i.adr == wb_addr_t'(`SFP_REG_CTRL));

always_ff @(posedge clk_125mhz_int) begin
    if (rst_i) begin
        ctrl_q <= CTRL_RESET;
    end else if (wr_ctrl) begin
        ctrl_q <= sfp_ctrl_t'(wb_req_i.dat[CTRL_W-1:0]);
    end
end

// Sticky events, write 1 to clear

always_comb begin
    clear_mask = '0;
    if (wr_access && (wb_req_i.adr == wb_addr_t'(`SFP_REG_EVENT))) begin
        clear_mask = sfp_event_t'(wb_req_i.dat[EVENT_W-1:0]);
    end
end

// A new event in the clearing cycle keeps its bit set
always_ff @(posedge clk_125mhz_int) begin
    if (rst_i) begin
        pending_q <= '0;
    end else begin
        pending_q <= sfp_event_t'((pending_q & ~clear_mask) | events_i);
    end
end

assign ctrl_o    = ctrl_q;
assign pending_o = pending_q;
assign wb_rsp_o  = '{ack: ack_q, dat: rdata_q};

endmodule

/* verilog/status_sync.sv */
// SFP pin synchronizer and edge detector
`timescale 1ns/1ps
`include "sfp_consts.svh"

module status_sync (
    input  logic                   clk_125mhz_int,
    input  logic                   rst_i,
    input  sfp_pkg::sfp_pins_t     pins_i,
    output sfp_pkg::sfp_pins_t     pins_o,
    output sfp_pkg::sfp_event_t    events_o
);

import sfp_pkg::*;

localparam int STAGES = `SFP_SYNC_STAGES;

// Stage 0 samples the asynchronous pins
sfp_pins_t sync_q [STAGES];
sfp_pins_t pins_s;
sfp_pins_t prev_q;

always_ff @(posedge clk_125mhz_int) begin
    sync_q[0] <= pins_i;
    for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
    end
end

assign pins_s = sync_q[STAGES-1];

// Cleared in reset so a pin already high gives one event
always_ff @(posedge clk_125mhz_int) begin
    if (rst_i) begin
        prev_q <= '0;
    end else begin
        prev_q <= pins_s;
    end
end

assign pins_o = pins_s;

// One-cycle pulses, aligned with the rise of pins_o
assign events_o.mod_abs_rise  = pins_s.mod_abs && !prev_q.mod_abs;
assign events_o.rx_los_rise   = pins_s.rx_los && !prev_q.rx_los;
assign events_o.tx_fault_rise = pins_s.tx_fault && !prev_q.tx_fault;

endmodule

/* verilog/reset_sync.sv */
// Synchronous reset stretcher
`timescale 1ns/1ps
`include "sfp_consts.svh"

module reset_sync #(
    parameter int N = `SFP_RST_STAGES
) (
    input  logic clk_125mhz_int,
    input  logic reset_i,
    output logic rst_o
);

// Loaded with ones during reset, drained by zeros afterwards
logic [N-1:0] stretch_q;

always_ff @(posedge clk_125mhz_int) begin
    if (reset_i) begin
        stretch_q <= '1;
    end else begin
        stretch_q <= stretch_q << 1;
    end
end

// Held for N cycles after reset_i falls
assign rst_o = stretch_q[N-1];

endmodule

/* verilog/wb_pkg.sv */
// Wishbone classic bus types
`include "sfp_consts.svh"

package wb_pkg;

    typedef logic [`SFP_ADDR_W-1:0] wb_addr_t;
    typedef logic [`SFP_DATA_W-1:0] wb_data_t;

    // Master to slave, held until ack
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Slave to master, dat valid with ack
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

/* verilog/sfp_pkg.sv */
// SFP cage pin types
package sfp_pkg;

    // Cage inputs after the pads
    // Last field is bit 0, so mod_abs lands in status bit 0
    typedef struct packed {
        logic sda;
        logic scl;
        logic tx_fault;
        logic rx_los;
        logic mod_abs;
    } sfp_pins_t;

    // Rising-edge events, same order as the event register
    typedef struct packed {
        logic tx_fault_rise;
        logic rx_los_rise;
        logic mod_abs_rise;
    } sfp_event_t;

    // Control word
    // scl_low and sda_low pull the open-drain lines low
    typedef struct packed {
        logic sda_low;
        logic scl_low;
        logic tx_disable;
    } sfp_ctrl_t;

endpackage

/* verilog/sfp_consts.svh */
// SFP board constants
`ifndef SFP_CONSTS_SVH
`define SFP_CONSTS_SVH

// Wishbone word address and data widths
`define SFP_ADDR_W 4
`define SFP_DATA_W 32

// Register word addresses
`define SFP_REG_CTRL   0
`define SFP_REG_STATUS 1
`define SFP_REG_EVENT  2
`define SFP_REG_ID     3

// Value returned by the ID register
`define SFP_ID_VALUE 32'h5F90_0001

// Reset stretch and synchronizer depth
`define SFP_RST_STAGES  4
`define SFP_SYNC_STAGES 2

// LED dividers in clock cycles, small enough for simulation
`define SFP_HEARTBEAT_DIV 16
`define SFP_BLINK_DIV     8

`endif
